//--- project.f
hdl/ex_pkg.sv
hdl/ex_control.sv
hdl/ex_alu.sv
hdl/ex_branch_unit.sv
hdl/ex_result_stage.sv
hdl/ex_stage_top.sv
verification/ex_clock_gen.sv
verification/tb_ex_stage.sv

//--- run_sim.sh
#!/bin/sh
# Builds the execute stage testbench with Verilator, runs it and scans the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_ex_stage \
    -f project.f -o tb_ex_stage > build.log 2>&1 \
    && ./obj_dir/tb_ex_stage > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or run error"; exit 1; }
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1 || exit 0

//--- verification/ex_stimulus.txt
// id op rs rt imm sh cond dest pc sp | result store dest ctl target mask, all hex
// ctl = mem_read mem_write reg_write pc_redirect, mask = target dest store result
01 0 1234 1111 0000 0 0 3 0100 0000  2345 1111 3 2 0000 7  // add
02 0 7fff 0001 0000 0 0 4 0102 0000  8000 0001 4 2 0000 7  // add overflow
03 c 0000 0000 0010 0 6 0 0200 0000  0000 0000 0 1 0210 8  // b ovf taken
04 1 8000 0001 0000 0 0 5 0104 0000  7fff 0001 5 2 0000 7  // sub overflow
05 c 0000 0000 0010 0 3 0 0210 0000  0000 0000 0 0 0000 0  // b lt not taken
06 1 0005 0005 0000 0 0 6 0106 0000  0000 0005 6 2 0000 7  // sub to zero
07 f 0000 0000 0000 0 0 0 0108 0000  0000 0000 0 0 0000 0  // nop keeps flags
08 c 0000 0000 fff0 0 1 0 0300 0000  0000 0000 0 1 02f0 8  // b eq taken
09 1 0003 0005 0000 0 0 7 010a 0000  fffe 0005 7 2 0000 7  // sub negative
0a 2 ffff ffff 0000 0 0 8 010c 0000  0000 ffff 8 2 0000 7  // nand to zero
0b c 0000 0000 0004 0 5 0 0400 0000  0000 0000 0 1 0404 8  // b le taken
0c c 0000 0000 0004 0 2 0 0404 0000  0000 0000 0 0 0000 0  // b gt not taken
0d 3 0f0f 0ff0 0000 0 0 9 010e 0000  00ff 0ff0 9 2 0000 7  // xor keeps n
0e c 0000 0000 0020 0 3 0 0500 0000  0000 0000 0 1 0520 8  // b lt taken
0f 4 0001 0000 0000 4 0 a 0110 0000  0010 0000 a 2 0000 7  // sll
10 5 8000 0000 0000 3 0 b 0112 0000  1000 0000 b 2 0000 7  // srl
11 6 8000 0000 0000 3 0 c 0114 0000  f000 0000 c 2 0000 7  // sra sign fill
12 6 4000 0000 0000 f 0 d 0116 0000  0000 0000 d 2 0000 7  // sra to zero
13 c 0000 0000 0008 0 0 0 0600 0000  0000 0000 0 0 0000 0  // b ne not taken
14 c 0000 0000 0008 0 4 0 0600 0000  0000 0000 0 1 0608 8  // b ge taken
15 a 0000 1234 ffab 0 0 1 0118 0000  ab34 1234 1 2 0000 7  // lhb
16 b 0000 1234 00cd 0 0 2 011a 0000  12cd 1234 2 2 0000 7  // llb
17 8 1000 5555 fffc 0 0 3 011c 0000  0ffc 5555 3 a 0000 7  // lw
18 9 2000 beef 0010 0 0 0 011e 0000  2010 beef 0 4 0000 3  // sw
19 d 0000 0000 0789 0 0 2 3456 0000  0000 3456 f 7 3789 e  // call
1a e 0000 0000 0000 0 0 0 3458 4242  0000 0000 f 3 4242 c  // ret
1b c 0000 0000 0002 0 7 0 0700 0000  0000 0000 0 1 0702 8  // b always

//--- verification/tb_ex_stage.sv
// Execute stage testbench, replays stimulus vectors and checks every registered response
`timescale 1ns/10ps
`default_nettype none

module tb_ex_stage;
    import ex_pkg::*;

    localparam int nwords   = 16;               // Words per vector line
    localparam int max_vecs = 64;

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    ex_opcode_e           opcode;
    logic [data_w-1:0]    rs_data;
    logic [data_w-1:0]    rt_data;
    logic [data_w-1:0]    imm;
    logic [3:0]           shamt;
    ex_cond_e             cond;
    logic [reg_idx_w-1:0] dest;
    logic [data_w-1:0]    pc;
    logic [data_w-1:0]    sp_value;
    logic                 out_valid;
    logic [data_w-1:0]    result;
    logic [data_w-1:0]    store_data;
    logic [reg_idx_w-1:0] out_dest;
    logic                 reg_write;
    logic                 mem_read;
    logic                 mem_write;
    logic                 mem_to_reg;
    logic                 pc_redirect;
    logic [data_w-1:0]    pc_target;

    logic [15:0] vec_mem [max_vecs*nwords];     // Flat store, nwords per vector
    int          vec_count;
    int          cycle_count = 0;
    int          cycle_limit = 1000;            // Replaced once vectors are counted
    int          pass_count  = 0;
    int          fail_count  = 0;
    bit          test_bad    = 1'b0;

    ex_clock_gen #(.period_ns(100)) u_clk (.clk(clk));
    ex_stage_top #(.STACK_REG(15)) u_dut (.*);

    ////////////////////////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////////////////////////
    task automatic report_mismatch(string test, string what, logic [15:0] exp,
                                   logic [15:0] act);
        $display("ERR %s %s expected %h actual %h", test, what, exp, act);
        test_bad = 1'b1;
    endtask

    // One summary line per test
    task automatic close_test(string test);
        if (test_bad) begin
            fail_count++;
            $display("FAIL %s", test);
        end else begin
            pass_count++;
            $display("PASS %s", test);
        end
        test_bad = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Vector access
    ////////////////////////////////////////////////////////////
    // Words 1 to 9 of the line are the DUT inputs
    task automatic apply_vector(int v, bit valid);
        int b;
        b        = v * nwords;
        in_valid = valid;
        opcode   = ex_opcode_e'(vec_mem[b+1][3:0]);
        rs_data  = vec_mem[b+2];
        rt_data  = vec_mem[b+3];
        imm      = vec_mem[b+4];
        shamt    = vec_mem[b+5][3:0];
        cond     = ex_cond_e'(vec_mem[b+6][2:0]);
        dest     = vec_mem[b+7][3:0];
        pc       = vec_mem[b+8];
        sp_value = vec_mem[b+9];
    endtask

    // Words 10 to 15 are the expected response, word 15 masks the payload checks
    task automatic check_vector(int v);
        int         b;
        ex_opcode_e op;
        string      name;
        b    = v * nwords;
        op   = ex_opcode_e'(vec_mem[b+1][3:0]);
        name = $sformatf("%0d_%s", vec_mem[b], op.name());
        if (out_valid !== 1'b1)
            report_mismatch(name, "out_valid", 16'h1, {15'h0, out_valid});
        if ({mem_read, mem_write, reg_write, pc_redirect} !== vec_mem[b+13][3:0])
            report_mismatch(name, "ctl", vec_mem[b+13],
                            {12'h0, mem_read, mem_write, reg_write, pc_redirect});
        // Only a load writes memory data back
        if (mem_to_reg !== vec_mem[b+13][3])
            report_mismatch(name, "mem_to_reg", {15'h0, vec_mem[b+13][3]},
                            {15'h0, mem_to_reg});
        if (vec_mem[b+15][0] && (result !== vec_mem[b+10]))
            report_mismatch(name, "result", vec_mem[b+10], result);
        if (vec_mem[b+15][1] && (store_data !== vec_mem[b+11]))
            report_mismatch(name, "store_data", vec_mem[b+11], store_data);
        if (vec_mem[b+15][2] && (out_dest !== vec_mem[b+12][3:0]))
            report_mismatch(name, "out_dest", vec_mem[b+12], {12'h0, out_dest});
        if (vec_mem[b+15][3] && (pc_target !== vec_mem[b+14]))
            report_mismatch(name, "pc_target", vec_mem[b+14], pc_target);
        close_test(name);
    endtask

    // Watchdog
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout, run still busy after %0d cycles", cycle_limit);
            $display("Simulation FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        rst_n = 1'b0;
        for (int k = 0; k < max_vecs*nwords; k++)
            vec_mem[k] = '0;
        apply_vector(0, 1'b0);                  // All inputs zero before load
        $readmemh("verification/ex_stimulus.txt", vec_mem);
        vec_count = 0;
        while (vec_count < max_vecs && vec_mem[vec_count*nwords] != 16'h0)
            vec_count++;                        // Ids start at 1, zero ends the list
        cycle_limit = 10 + 2*vec_count + 20;
        if (vec_count == 0) begin
            $display("No vectors found in verification/ex_stimulus.txt");
            fail_count++;
        end

        repeat (10) @(posedge clk);
        #5 rst_n = 1'b1;
        if ({out_valid, pc_redirect, reg_write, mem_read, mem_write} !== 5'b0)
            report_mismatch("reset", "valid_ctl", 16'h0,
                            {11'h0, out_valid, pc_redirect, reg_write, mem_read, mem_write});
        close_test("reset");

        // Back-to-back issue, response checked one edge later
        if (vec_count > 0)
            apply_vector(0, 1'b1);
        for (int i = 0; i < vec_count; i++) begin
            @(posedge clk);
            #5;
            check_vector(i);
            if (i + 1 < vec_count)
                apply_vector(i + 1, 1'b1);
            else
                in_valid = 1'b0;
        end

        // Pipe drains once issue stops
        @(posedge clk);
        #5;
        if (out_valid !== 1'b0)
            report_mismatch("drain", "out_valid", 16'h0, {15'h0, out_valid});
        close_test("drain");

        $display("Tests: %0d run, %0d passed, %0d failed",
                 pass_count + fail_count, pass_count, fail_count);
        if (fail_count == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/ex_clock_gen.sv
// Free-running testbench clock, 50 percent duty cycle
`timescale 1ns/10ps
`default_nettype none

module ex_clock_gen #(
    parameter int period_ns = 100       // Full period
) (
    output logic clk
);
    initial begin
        clk = 1'b0;                     // First rising edge at half a period
        forever #(period_ns / 2) clk = ~clk;
    end
endmodule

`default_nettype wire

//--- hdl/ex_stage_top.sv
// Execute stage top, ties decode, ALU, branch unit and result register together
`timescale 1ns/10ps
`default_nettype none

module ex_stage_top #(
    parameter int unsigned STACK_REG = 15              // Stack pointer register index
) (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          in_valid,    // One-cycle issue strobe
    input  wire ex_pkg::ex_opcode_e            opcode,
    input  wire logic [ex_pkg::data_w-1:0]     rs_data,
    input  wire logic [ex_pkg::data_w-1:0]     rt_data,
    input  wire logic [ex_pkg::data_w-1:0]     imm,         // Sign-extended
    input  wire logic [3:0]                    shamt,
    input  wire ex_pkg::ex_cond_e              cond,
    input  wire logic [ex_pkg::reg_idx_w-1:0]  dest,
    input  wire logic [ex_pkg::data_w-1:0]     pc,
    input  wire logic [ex_pkg::data_w-1:0]     sp_value,
    output logic                               out_valid,
    output logic      [ex_pkg::data_w-1:0]     result,
    output logic      [ex_pkg::data_w-1:0]     store_data,
    output logic      [ex_pkg::reg_idx_w-1:0]  out_dest,
    output logic                               reg_write,
    output logic                               mem_read,
    output logic                               mem_write,
    output logic                               mem_to_reg,
    output logic                               pc_redirect,
    output logic      [ex_pkg::data_w-1:0]     pc_target
);
    import ex_pkg::*;

    alu_op_e              alu_op;
    logic                 alu_src_imm;
    logic                 flag_en;
    logic                 load_half;
    logic                 half_low;
    logic                 is_branch;
    logic                 is_call;
    logic                 is_ret;
    logic [reg_idx_w-1:0] wb_dest;
    logic                 ctl_valid;
    logic                 ctl_reg_write;
    logic                 ctl_mem_read;
    logic                 ctl_mem_write;
    logic                 ctl_mem_to_reg;
    logic [data_w-1:0]    alu_b;        // Operand 2
    logic [data_w-1:0]    alu_out;
    logic [2:0]           alu_flags;

    assign alu_b = alu_src_imm ? imm : rt_data;

    ////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////
    ex_control #(.STACK_REG(STACK_REG)) u_control (
        .clk(clk), .rst_n(rst_n), .in_valid(in_valid), .opcode(opcode), .dest(dest),
        .alu_op(alu_op), .alu_src_imm(alu_src_imm), .flag_en(flag_en),
        .load_half(load_half), .half_low(half_low), .is_branch(is_branch),
        .is_call(is_call), .is_ret(is_ret), .wb_dest(wb_dest), .ctl_valid(ctl_valid),
        .ctl_reg_write(ctl_reg_write), .ctl_mem_read(ctl_mem_read),
        .ctl_mem_write(ctl_mem_write), .ctl_mem_to_reg(ctl_mem_to_reg));

    ex_alu u_alu (
        .a(rs_data), .b(alu_b), .shamt(shamt), .alu_op(alu_op),
        .alu_out(alu_out), .alu_flags(alu_flags));

    ex_branch_unit u_branch (
        .clk(clk), .rst_n(rst_n), .flag_en(flag_en), .alu_op(alu_op),
        .alu_flags(alu_flags), .is_branch(is_branch), .is_call(is_call), .is_ret(is_ret),
        .cond(cond), .pc(pc), .imm(imm), .sp_value(sp_value),
        .pc_redirect(pc_redirect), .pc_target(pc_target));

    ex_result_stage u_result (
        .clk(clk), .rst_n(rst_n), .ctl_valid(ctl_valid), .ctl_reg_write(ctl_reg_write),
        .ctl_mem_read(ctl_mem_read), .ctl_mem_write(ctl_mem_write),
        .ctl_mem_to_reg(ctl_mem_to_reg), .wb_dest(wb_dest), .load_half(load_half),
        .half_low(half_low), .is_call(is_call), .alu_out(alu_out), .rt_data(rt_data),
        .imm(imm), .pc(pc), .out_valid(out_valid), .result(result),
        .store_data(store_data), .out_dest(out_dest), .reg_write(reg_write),
        .mem_read(mem_read), .mem_write(mem_write), .mem_to_reg(mem_to_reg));

endmodule

`default_nettype wire

//--- hdl/ex_result_stage.sv
// Execute stage output register, load-half merge and store data select
`timescale 1ns/10ps
`default_nettype none

module ex_result_stage (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          ctl_valid,
    input  wire logic                          ctl_reg_write,
    input  wire logic                          ctl_mem_read,
    input  wire logic                          ctl_mem_write,
    input  wire logic                          ctl_mem_to_reg,
    input  wire logic [ex_pkg::reg_idx_w-1:0]  wb_dest,
    input  wire logic                          load_half,
    input  wire logic                          half_low,
    input  wire logic                          is_call,
    input  wire logic [ex_pkg::data_w-1:0]     alu_out,
    input  wire logic [ex_pkg::data_w-1:0]     rt_data,
    input  wire logic [ex_pkg::data_w-1:0]     imm,
    input  wire logic [ex_pkg::data_w-1:0]     pc,
    output logic                               out_valid,
    output logic      [ex_pkg::data_w-1:0]     result,      // ALU result or address
    output logic      [ex_pkg::data_w-1:0]     store_data,
    output logic      [ex_pkg::reg_idx_w-1:0]  out_dest,
    output logic                               reg_write,
    output logic                               mem_read,
    output logic                               mem_write,
    output logic                               mem_to_reg
);
    import ex_pkg::*;

    logic [data_w-1:0] half_merged;
    logic [data_w-1:0] result_d;
    logic [data_w-1:0] store_d;

    // Immediate byte replaces one half of rt
    assign half_merged = half_low ? {rt_data[data_w-1:8], imm[7:0]}   // LLB
                                  : {imm[7:0], rt_data[7:0]};          // LHB
    assign result_d    = load_half ? half_merged : alu_out;
    assign store_d     = is_call ? pc : rt_data;    // Call pushes return address

    ////////////////////////////////////////////////////////////
    // Pipeline register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            reg_write  <= 1'b0;
            mem_read   <= 1'b0;
            mem_write  <= 1'b0;
            mem_to_reg <= 1'b0;
        end else begin
            out_valid  <= ctl_valid;
            reg_write  <= ctl_reg_write;
            mem_read   <= ctl_mem_read;
            mem_write  <= ctl_mem_write;
            mem_to_reg <= ctl_mem_to_reg;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        result     <= result_d;
        store_data <= store_d;
        out_dest   <= wb_dest;
    end

    // Memory stage sees one access kind at a time
    a_mem_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write));

endmodule

`default_nettype wire

//--- hdl/ex_branch_unit.sv
// Execute stage branch unit, flag register, condition check and registered redirect
`timescale 1ns/10ps
`default_nettype none

module ex_branch_unit (
    input  wire logic                       clk,
    input  wire logic                       rst_n,
    input  wire logic                       flag_en,      // Valid flag-setting op
    input  wire ex_pkg::alu_op_e            alu_op,
    input  wire logic [2:0]                 alu_flags,
    input  wire logic                       is_branch,
    input  wire logic                       is_call,
    input  wire logic                       is_ret,
    input  wire ex_pkg::ex_cond_e           cond,
    input  wire logic [ex_pkg::data_w-1:0]  pc,           // Next instruction address
    input  wire logic [ex_pkg::data_w-1:0]  imm,
    input  wire logic [ex_pkg::data_w-1:0]  sp_value,     // Popped return address
    output logic                            pc_redirect,
    output logic      [ex_pkg::data_w-1:0]  pc_target
);
    import ex_pkg::*;

    logic [2:0]        flags_q;     // Z, V, N as of the last flag-setting op
    logic              taken;
    logic [data_w-1:0] target_d;

    ////////////////////////////////////////////////////////////
    // Flag register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags_q <= '0;
        end else if (flag_en) begin
            flags_q[flag_z] <= alu_flags[flag_z];           // Every flag op
            if (alu_op == ALU_ADD || alu_op == ALU_SUB) begin
                flags_q[flag_v] <= alu_flags[flag_v];       // Arithmetic only
                flags_q[flag_n] <= alu_flags[flag_n];
            end
        end
    end

    // Condition against the stored flags, not this cycle's ALU
    always_comb begin
        case (cond)
            COND_NE:  taken = !flags_q[flag_z];
            COND_EQ:  taken = flags_q[flag_z];
            COND_GT:  taken = !flags_q[flag_z] && !flags_q[flag_n];
            COND_LT:  taken = flags_q[flag_n];
            COND_GE:  taken = flags_q[flag_z] || !flags_q[flag_n];
            COND_LE:  taken = flags_q[flag_z] || flags_q[flag_n];
            COND_OVF: taken = flags_q[flag_v];
            default:  taken = 1'b1;                         // Unconditional
        endcase
    end

    // Target select
    always_comb begin
        if (is_call) begin
            target_d = {pc[data_w-1:12], imm[11:0]};        // Page-relative call
        end else if (is_ret) begin
            target_d = sp_value;
        end else begin
            target_d = pc + imm;                            // Relative branch
        end
    end

    ////////////////////////////////////////////////////////////
    // Redirect register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_redirect <= 1'b0;
        end else begin
            pc_redirect <= is_call || is_ret || (is_branch && taken);
        end
    end

    always_ff @(posedge clk) begin
        pc_target <= target_d;
    end

    // Back-to-back redirects need a control transfer issued behind each
    a_redirect_src: assert property (@(posedge clk) disable iff (!rst_n)
        pc_redirect && $past(pc_redirect) |-> $past(is_branch || is_call || is_ret));

endmodule

`default_nettype wire

//--- hdl/ex_alu.sv
// Execute stage ALU, add/sub/nand/xor/shifts with zero, overflow and sign flags
`timescale 1ns/10ps
`default_nettype none

module ex_alu (
    input  wire logic [ex_pkg::data_w-1:0]  a,          // rs operand
    input  wire logic [ex_pkg::data_w-1:0]  b,          // rt or imm
    input  wire logic [3:0]                 shamt,      // Shift amount
    input  wire ex_pkg::alu_op_e            alu_op,
    output logic      [ex_pkg::data_w-1:0]  alu_out,
    output logic      [2:0]                 alu_flags   // Z, V, N by flag index
);
    import ex_pkg::*;

    logic [data_w-1:0] sum;
    logic [data_w-1:0] diff;
    logic              add_ovf;
    logic              sub_ovf;

    ////////////////////////////////////////////////////////////
    // Adder paths
    ////////////////////////////////////////////////////////////
    assign sum  = a + b;            // Wraps on overflow
    assign diff = a - b;

    // Like signs in, other sign out
    assign add_ovf = (a[data_w-1] == b[data_w-1]) && (sum[data_w-1] != a[data_w-1]);
    // Unlike signs in, result sign differs from a
    assign sub_ovf = (a[data_w-1] != b[data_w-1]) && (diff[data_w-1] != a[data_w-1]);

    // Result select
    always_comb begin
        case (alu_op)
            ALU_ADD:  alu_out = sum;
            ALU_SUB:  alu_out = diff;
            ALU_NAND: alu_out = ~(a & b);
            ALU_XOR:  alu_out = a ^ b;
            ALU_SLL:  alu_out = a << shamt;
            ALU_SRL:  alu_out = a >> shamt;             // Zero fill
            ALU_SRA:  alu_out = $signed(a) >>> shamt;   // Sign fill
            default:  alu_out = '0;
        endcase
    end

    // Flags from the result, overflow only meaningful for add/sub
    always_comb begin
        alu_flags         = '0;
        alu_flags[flag_z] = (alu_out == '0);
        alu_flags[flag_n] = alu_out[data_w-1];
        case (alu_op)
            ALU_ADD: alu_flags[flag_v] = add_ovf;
            ALU_SUB: alu_flags[flag_v] = sub_ovf;
            default: alu_flags[flag_v] = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/ex_control.sv
// Execute stage decoder, opcode to datapath selects and gated control strobes
`timescale 1ns/10ps
`default_nettype none

module ex_control #(
    parameter int unsigned STACK_REG = 15             // Stack pointer register index
) (
    input  wire logic                           clk,
    input  wire logic                           rst_n,
    input  wire logic                           in_valid,      // Issue strobe
    input  wire ex_pkg::ex_opcode_e             opcode,
    input  wire logic [ex_pkg::reg_idx_w-1:0]   dest,
    output ex_pkg::alu_op_e                     alu_op,
    output logic                                alu_src_imm,   // Operand 2 is imm
    output logic                                flag_en,
    output logic                                load_half,
    output logic                                half_low,      // LLB, else LHB
    output logic                                is_branch,
    output logic                                is_call,
    output logic                                is_ret,
    output logic [ex_pkg::reg_idx_w-1:0]        wb_dest,
    output logic                                ctl_valid,
    output logic                                ctl_reg_write,
    output logic                                ctl_mem_read,
    output logic                                ctl_mem_write,
    output logic                                ctl_mem_to_reg
);
    import ex_pkg::*;

    // Raw decode, before the issue strobe qualifies it
    logic dec_reg_write;
    logic dec_mem_read;
    logic dec_mem_write;
    logic dec_mem_to_reg;
    logic dec_flag_en;
    logic dec_branch;
    logic dec_call;
    logic dec_ret;

    ////////////////////////////////////////////////////////////
    // Opcode decode
    ////////////////////////////////////////////////////////////
    always_comb begin
        alu_op         = ALU_ADD;   // Address and stack adds
        alu_src_imm    = 1'b0;
        load_half      = 1'b0;
        half_low       = 1'b0;
        dec_reg_write  = 1'b0;
        dec_mem_read   = 1'b0;
        dec_mem_write  = 1'b0;
        dec_mem_to_reg = 1'b0;
        dec_flag_en    = 1'b0;
        dec_branch     = 1'b0;
        dec_call       = 1'b0;
        dec_ret        = 1'b0;
        case (opcode)
            OP_ADD, OP_SUB, OP_NAND, OP_XOR, OP_SLL, OP_SRL, OP_SRA: begin
                alu_op        = alu_op_e'(opcode[2:0]);  // Codes line up
                dec_reg_write = 1'b1;
                dec_flag_en   = 1'b1;
            end
            OP_LW: begin
                alu_src_imm    = 1'b1;      // rs + imm
                dec_reg_write  = 1'b1;
                dec_mem_read   = 1'b1;
                dec_mem_to_reg = 1'b1;
            end
            OP_SW: begin
                alu_src_imm   = 1'b1;
                dec_mem_write = 1'b1;
            end
            OP_LHB, OP_LLB: begin
                load_half     = 1'b1;
                half_low      = (opcode == OP_LLB);
                dec_reg_write = 1'b1;
            end
            OP_B:    dec_branch = 1'b1;
            OP_CALL: begin
                dec_call      = 1'b1;
                dec_reg_write = 1'b1;       // Updated stack pointer
                dec_mem_write = 1'b1;       // Push return address
            end
            OP_RET: begin
                dec_ret       = 1'b1;
                dec_reg_write = 1'b1;
            end
            default: ;                      // NOP and unused codes
        endcase
    end

    // Strobes only live in the issue cycle
    assign ctl_valid      = in_valid;
    assign ctl_reg_write  = in_valid && dec_reg_write;
    assign ctl_mem_read   = in_valid && dec_mem_read;
    assign ctl_mem_write  = in_valid && dec_mem_write;
    assign ctl_mem_to_reg = in_valid && dec_mem_to_reg;
    assign flag_en        = in_valid && dec_flag_en;
    assign is_branch      = in_valid && dec_branch;
    assign is_call        = in_valid && dec_call;
    assign is_ret         = in_valid && dec_ret;

    // Call and return write back the stack pointer
    assign wb_dest = (dec_call || dec_ret) ? reg_idx_w'(STACK_REG) : dest;

    // At most one kind of control transfer per issue
    a_xfer_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({is_branch, is_call, is_ret}));

endmodule

`default_nettype wire

//--- hdl/ex_pkg.sv
// Execute stage shared widths, flag positions and encodings
`default_nettype none

package ex_pkg;

    ////////////////////////////////////////////////////////////
    // Widths and flag layout
    ////////////////////////////////////////////////////////////
    localparam int data_w    = 16;      // Fixed by the instruction set
    localparam int reg_idx_w = 4;       // 16 architectural registers

    localparam int flag_z = 0;          // Zero
    localparam int flag_v = 1;          // Signed overflow
    localparam int flag_n = 2;          // Negative

    // Decoded instruction opcodes
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_NAND = 4'h2,
        OP_XOR  = 4'h3,
        OP_SLL  = 4'h4,
        OP_SRL  = 4'h5,
        OP_SRA  = 4'h6,
        OP_LW   = 4'h8,
        OP_SW   = 4'h9,
        OP_LHB  = 4'ha,
        OP_LLB  = 4'hb,
        OP_B    = 4'hc,
        OP_CALL = 4'hd,
        OP_RET  = 4'he,
        OP_NOP  = 4'hf
    } ex_opcode_e;

    // ALU operations, same codes as the low opcode bits
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SUB  = 3'd1,
        ALU_NAND = 3'd2,
        ALU_XOR  = 3'd3,
        ALU_SLL  = 3'd4,
        ALU_SRL  = 3'd5,
        ALU_SRA  = 3'd6
    } alu_op_e;

    // Branch conditions as carried in the instruction
    typedef enum logic [2:0] {
        COND_NE = 3'd0, COND_EQ = 3'd1, COND_GT  = 3'd2, COND_LT     = 3'd3,
        COND_GE = 3'd4, COND_LE = 3'd5, COND_OVF = 3'd6, COND_ALWAYS = 3'd7
    } ex_cond_e;

endpackage

`default_nettype wire
